// ==== sources.f ====
hdl/issue_pkg.sv
hdl/arch_regs.sv
hdl/operand_fetch.sv
hdl/issue_queue.sv
hdl/issue_stage.sv
test/issue_stage_assertions.sv
test/issue_stage_tb.sv

// ==== Bender.yml ====
package:
  name: issue_stage

sources:
  - hdl/issue_pkg.sv
  - hdl/arch_regs.sv
  - hdl/operand_fetch.sv
  - hdl/issue_queue.sv
  - hdl/issue_stage.sv
  - target: test
    files:
      - test/issue_stage_assertions.sv
      - test/issue_stage_tb.sv

// ==== test/issue_stage_tb.sv ====
`timescale 1ns/1ps

module issue_stage_tb;

    import issue_pkg::*;

    localparam time         CLK_PERIOD = 20;
    localparam logic [31:0] SEED       = 32'h8353_b6ed;
    localparam word_t       PC_BASE    = 32'h0040_0000;
    localparam int          N          = 255;
    localparam int          N_PROG     = 35;

    // ctl bits from msb down are regwrite memtoreg memwrite alusrc signext branch jump jr
    // is_link hiwrite lowrite hitoreg lotoreg
    localparam ctl_t CTL_R    = 13'b1_0_0_0_0_0_0_0_0_0_0_0_0;
    localparam ctl_t CTL_ISE  = 13'b1_0_0_1_1_0_0_0_0_0_0_0_0;
    localparam ctl_t CTL_IZE  = 13'b1_0_0_1_0_0_0_0_0_0_0_0_0;
    localparam ctl_t CTL_LW   = 13'b1_1_0_1_1_0_0_0_0_0_0_0_0;
    localparam ctl_t CTL_SW   = 13'b0_0_1_1_1_0_0_0_0_0_0_0_0;
    localparam ctl_t CTL_BR   = 13'b0_0_0_0_1_1_0_0_0_0_0_0_0;
    localparam ctl_t CTL_JAL  = 13'b1_0_0_0_0_0_1_0_1_0_0_0_0;
    localparam ctl_t CTL_MTHI = 13'b0_0_0_0_0_0_0_0_0_1_0_0_0;
    localparam ctl_t CTL_MFHI = 13'b1_0_0_0_0_0_0_0_0_0_0_1_0;

    // one row per clock, holding prog indexes or N for an empty slot
    typedef struct packed {
        logic [7:0] in1;
        logic [7:0] in0;
        logic       flush;
        logic       stall;
        reg_addr_t  wb_reg;
        logic       ready;
        logic [7:0] out1;
        logic [7:0] out0;
    } row_t;

    logic                   clk;
    logic                   reset;
    decode_entry_t [1:0]    dec_in;
    logic [1:0]             dec_valid;
    logic                   dec_ready;
    logic                   flush;
    logic                   ex_stall;
    writeback_t [1:0]       wb;
    issue_entry_t [1:0]     issue_out;

    decode_entry_t prog [N_PROG];
    row_t          rows [48];
    int            n_rows = 0;
    word_t         shadow [32];
    word_t         shadow_hi;
    word_t         shadow_lo;
    logic [31:0]   rng_state;

    issue_stage #(
        .QUEUE_DEPTH (8)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .dec_in    (dec_in),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .flush     (flush),
        .ex_stall  (ex_stall),
        .wb        (wb),
        .issue_out (issue_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic word_t rword(input reg_addr_t rs, input reg_addr_t rt,
                                    input reg_addr_t rd, input logic [5:0] funct);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t iword(input logic [5:0] op, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic decode_entry_t mk(input int idx, input word_t word, input ctl_t ctl,
                                         input reg_addr_t dest);
        decode_entry_t d;
        d.pc      = PC_BASE + word_t'(4 * idx);
        d.instr   = instr_word_u'(word);
        d.ctl     = ctl;
        d.destreg = dest;
        return d;
    endfunction

    function automatic logic is_bj(input ctl_t c);
        return c.branch || c.jump || c.jr;
    endfunction

    // issued slot as the pairing and operand rules define it
    function automatic issue_entry_t expect_issue(input logic [7:0] idx, input logic in_delay);
        decode_entry_t d;
        issue_entry_t  e;
        logic [15:0]   imm;
        e = '0;
        if (int'(idx) == N)
            return e;
        d   = prog[idx];
        imm = d.instr[15:0];
        e.valid      = 1'b1;
        e.pc         = d.pc;
        e.ctl        = d.ctl;
        e.destreg    = d.destreg;
        e.srca       = shadow[d.instr[25:21]];
        e.store_data = shadow[d.instr[20:16]];
        if (!d.ctl.alusrc)
            e.srcb = e.store_data;
        else if (d.ctl.signext)
            e.srcb = {{16{imm[15]}}, imm};
        else
            e.srcb = {16'h0000, imm};
        e.hi         = shadow_hi;
        e.lo         = shadow_lo;
        e.delay_slot = in_delay;
        if (d.ctl.is_link)
            e.link_pc = d.pc + 32'd8;
        return e;
    endfunction

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_issue(input string name, input issue_entry_t exp,
                               input issue_entry_t got);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s expected %b got %b", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic set_wb(input int port, input reg_addr_t addr);
        word_t data;
        data          = next_rand();
        wb[port].en   = 1'b1;
        wb[port].addr = addr;
        wb[port].data = data;
        shadow[addr]  = data;
    endtask

    task automatic add_row(input int in1, input int in0, input bit fl, input bit st,
                           input int wbr, input bit rdy, input int out1, input int out0);
        rows[n_rows] = {in1[7:0], in0[7:0], fl, st, wbr[4:0], rdy, out1[7:0], out0[7:0]};
        n_rows++;
    endtask

    task automatic build_program();
        prog[0]  = mk(0, rword(1, 2, 3, FN_ADDU), CTL_R, 3);
        prog[1]  = mk(1, iword(OP_ADDIU, 5, 4, 16'h8001), CTL_ISE, 4);
        prog[2]  = mk(2, iword(OP_ORI, 7, 6, 16'h8001), CTL_IZE, 6);
        prog[3]  = mk(3, rword(9, 10, 8, FN_SUBU), CTL_R, 8);
        prog[4]  = mk(4, iword(OP_ADDIU, 12, 11, 16'h0005), CTL_ISE, 11);
        prog[5]  = mk(5, rword(11, 14, 13, FN_ADDU), CTL_R, 13);
        prog[6]  = mk(6, rword(15, 0, 0, FN_MTHI), CTL_MTHI, 0);
        prog[7]  = mk(7, rword(0, 0, 16, FN_MFHI), CTL_MFHI, 16);
        prog[8]  = mk(8, iword(OP_LW, 18, 17, 16'h0010), CTL_LW, 17);
        prog[9]  = mk(9, iword(OP_SW, 20, 19, 16'hfff0), CTL_SW, 0);
        prog[10] = mk(10, {OP_JAL, 26'h010_0040}, CTL_JAL, LINK_REG);
        prog[11] = mk(11, rword(22, 23, 21, FN_ADDU), CTL_R, 21);
        prog[12] = mk(12, rword(25, 26, 24, FN_ADDU), CTL_R, 24);
        prog[13] = mk(13, iword(OP_BEQ, 1, 2, 16'h0004), CTL_BR, 0);
        prog[14] = mk(14, rword(28, 29, 27, FN_OR), CTL_R, 27);
        // independent filler whose dests 1..18 never overlap sources 20..31
        for (int k = 15; k < 33; k++)
            prog[k] = mk(k, rword(reg_addr_t'(20 + (k - 15) % 12),
                                  reg_addr_t'(31 - (k - 15) % 12),
                                  reg_addr_t'(k - 14), FN_ADDU), CTL_R, reg_addr_t'(k - 14));
        prog[33] = mk(33, rword(30, 1, 9, FN_ADDU), CTL_R, 9);
        prog[34] = mk(34, iword(OP_ORI, 11, 10, 16'h1234), CTL_IZE, 10);
    endtask

    task automatic build_table();
        // alu pairs, then raw, hi/lo and memory pairs split in order
        add_row(0, 1, 0, 0, 0, 1, N, N);
        add_row(2, 3, 0, 0, 0, 1, 0, 1);
        add_row(4, 5, 0, 0, 0, 1, 2, 3);
        add_row(N, N, 0, 0, 0, 1, 4, N);
        add_row(6, 7, 0, 0, 0, 1, 5, N);
        add_row(N, N, 0, 0, 0, 1, 6, N);
        add_row(8, 9, 0, 0, 0, 1, 7, N);
        add_row(N, N, 0, 0, 0, 1, 8, N);
        // jal waits for its delay slot and beq in the younger slot goes next time
        add_row(10, N, 0, 0, 0, 1, 9, N);
        add_row(N, N, 0, 0, 0, 1, N, N);
        add_row(11, N, 0, 0, 0, 1, N, N);
        add_row(12, 13, 0, 0, 0, 1, 10, 11);
        add_row(N, 14, 0, 0, 0, 1, 12, N);
        add_row(N, N, 0, 0, 0, 1, 13, 14);
        // fill all eight entries under stall
        add_row(15, 16, 0, 0, 0, 1, N, N);
        add_row(17, 18, 0, 0, 0, 1, 15, 16);
        add_row(19, 20, 0, 1, 0, 1, 15, 16);
        add_row(21, 22, 0, 1, 0, 1, 15, 16);
        add_row(23, 24, 0, 1, 0, 1, 15, 16);
        add_row(25, 26, 0, 1, 0, 0, 15, 16);
        add_row(25, 26, 0, 0, 0, 0, 17, 18);
        add_row(25, 26, 0, 0, 0, 1, 19, 20);
        add_row(N, N, 0, 0, 0, 1, 21, 22);
        add_row(N, N, 0, 0, 0, 1, 23, 24);
        add_row(N, N, 0, 0, 0, 1, 25, 26);
        // flush drops 29 and 30
        add_row(27, 28, 0, 0, 0, 1, N, N);
        add_row(29, 30, 0, 0, 0, 1, 27, 28);
        add_row(N, N, 1, 0, 0, 1, N, N);
        add_row(31, 32, 0, 0, 0, 1, N, N);
        add_row(33, 34, 0, 0, 0, 1, 31, 32);
        // r30 written in the issue cycle of 33
        add_row(N, N, 0, 0, 30, 1, 33, 34);
        add_row(N, N, 0, 0, 0, 1, N, N);
    endtask

    task automatic preload_regs();
        wb          = '0;
        wb[1].hi_en = 1'b1;
        wb[1].hi    = next_rand();
        wb[0].lo_en = 1'b1;
        wb[0].lo    = next_rand();
        shadow_hi   = wb[1].hi;
        shadow_lo   = wb[0].lo;
        @(negedge clk);
        for (int r = 1; r < 32; r += 2)
        begin
            wb = '0;
            set_wb(1, reg_addr_t'(r));
            if (r < 31)
                set_wb(0, reg_addr_t'(r + 1));
            @(negedge clk);
        end
        wb = '0;
    endtask

    task automatic run_row(input row_t r, input int idx);
        issue_entry_t exp1;
        issue_entry_t exp0;
        logic         in_delay;
        dec_in    = '0;
        dec_valid = '0;
        if (int'(r.in1) != N)
        begin
            dec_in[1]    = prog[r.in1];
            dec_valid[1] = 1'b1;
        end
        if (int'(r.in0) != N)
        begin
            dec_in[0]    = prog[r.in0];
            dec_valid[0] = 1'b1;
        end
        flush    = r.flush;
        ex_stall = r.stall;
        wb       = '0;
        if (r.wb_reg != '0)
            set_wb(0, r.wb_reg);
        #(CLK_PERIOD / 4);
        check_bit($sformatf("dec_ready row %0d", idx), r.ready, dec_ready);
        @(negedge clk);
        in_delay = 1'b0;
        if (int'(r.out1) != N)
            in_delay = is_bj(prog[r.out1].ctl);
        exp1 = expect_issue(r.out1, 1'b0);
        exp0 = expect_issue(r.out0, in_delay);
        check_issue($sformatf("issue_out[1] row %0d", idx), exp1, issue_out[1]);
        check_issue($sformatf("issue_out[0] row %0d", idx), exp0, issue_out[0]);
    endtask

    initial
    begin
        reset     = 1'b1;
        dec_in    = '0;
        dec_valid = '0;
        flush     = 1'b0;
        ex_stall  = 1'b0;
        wb        = '0;
        rng_state = SEED;
        shadow_hi = '0;
        shadow_lo = '0;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;
        build_program();
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        preload_regs();
        for (int i = 0; i < n_rows; i++)
            run_row(rows[i], i);
        $display("Finished with no errors");
        $finish;
    end

    // the bound checker counts its failed assertions
    always @(uut.checks.fail_count)
    begin
        if (uut.checks.fail_count != 0)
        begin
            $display("a bound assertion on issue_out failed");
            stop_run();
        end
    end

    // generous bound of twenty clocks per table row
    initial
    begin
        @(negedge reset);
        #(n_rows * 20 * CLK_PERIOD);
        $display("timeout: the stimulus table did not complete in time");
        stop_run();
    end

endmodule

// ==== test/issue_stage_assertions.sv ====
`timescale 1ns/1ps

module issue_stage_assertions (
    input logic                          clk,
    input logic                          reset,
    input logic                          flush,
    input logic                          ex_stall,
    input issue_pkg::issue_entry_t [1:0] issue_out
);

    int fail_count = 0;

    // output register holds while execute stalls
    stall_hold: assert property (@(posedge clk) disable iff (reset)
        ex_stall && !flush |=> $stable(issue_out))
        else
        begin
            fail_count++;
            $error("issue_out changed while ex_stall was high");
        end

    // the younger slot only goes out behind the older one
    slot_order: assert property (@(posedge clk) disable iff (reset)
        issue_out[0].valid |-> issue_out[1].valid)
        else
        begin
            fail_count++;
            $error("issue_out[0] valid while issue_out[1] is empty");
        end

    flush_clears: assert property (@(posedge clk) disable iff (reset)
        flush |=> !issue_out[1].valid && !issue_out[0].valid)
        else
        begin
            fail_count++;
            $error("issue_out not empty one cycle after flush");
        end

endmodule

bind issue_stage issue_stage_assertions checks (
    .clk       (clk),
    .reset     (reset),
    .flush     (flush),
    .ex_stall  (ex_stall),
    .issue_out (issue_out)
);

// ==== hdl/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  issue_pkg::decode_entry_t [1:0]  dec_in,
    input  logic [1:0]                      dec_valid,
    output logic                            dec_ready,
    input  logic                            flush,
    input  logic                            ex_stall,
    input  issue_pkg::writeback_t [1:0]     wb,
    output issue_pkg::issue_entry_t [1:0]   issue_out
);

    import issue_pkg::*;

    decode_entry_t   head_a;
    decode_entry_t   head_b;
    logic            head_b_delay_slot;
    issue_entry_t    built_a;
    issue_entry_t    built_b;

    // read ports 3 and 2 serve the older slot, 1 and 0 the younger
    reg_addr_t [3:0] raddr;
    word_t [3:0]     rdata;
    word_t           hi;
    word_t           lo;

    issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue (
        .clk               (clk),
        .reset             (reset),
        .dec_in            (dec_in),
        .dec_valid         (dec_valid),
        .dec_ready         (dec_ready),
        .flush             (flush),
        .ex_stall          (ex_stall),
        .head_a            (head_a),
        .head_b            (head_b),
        .head_a_valid      (),
        .head_b_valid      (),
        .head_b_delay_slot (head_b_delay_slot),
        .built_a           (built_a),
        .built_b           (built_b),
        .issue_out         (issue_out)
    );

    operand_fetch fetch_a (
        .entry         (head_a),
        .is_delay_slot (1'b0),
        .rs_addr       (raddr[3]),
        .rt_addr       (raddr[2]),
        .rs_data       (rdata[3]),
        .rt_data       (rdata[2]),
        .hi            (hi),
        .lo            (lo),
        .built         (built_a)
    );

    operand_fetch fetch_b (
        .entry         (head_b),
        .is_delay_slot (head_b_delay_slot),
        .rs_addr       (raddr[1]),
        .rt_addr       (raddr[0]),
        .rs_data       (rdata[1]),
        .rt_data       (rdata[0]),
        .hi            (hi),
        .lo            (lo),
        .built         (built_b)
    );

    arch_regs regs (
        .clk   (clk),
        .reset (reset),
        .raddr (raddr),
        .rdata (rdata),
        .hi    (hi),
        .lo    (lo),
        .wb    (wb)
    );

endmodule

// ==== hdl/issue_queue.sv ====
`timescale 1ns/1ps

module issue_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  issue_pkg::decode_entry_t [1:0]  dec_in,
    input  logic [1:0]                      dec_valid,
    output logic                            dec_ready,
    input  logic                            flush,
    input  logic                            ex_stall,
    output issue_pkg::decode_entry_t        head_a,
    output issue_pkg::decode_entry_t        head_b,
    output logic                            head_a_valid,
    output logic                            head_b_valid,
    output logic                            head_b_delay_slot,
    input  issue_pkg::issue_entry_t         built_a,
    input  issue_pkg::issue_entry_t         built_b,
    output issue_pkg::issue_entry_t [1:0]   issue_out
);

    import issue_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;

    decode_entry_t          entries [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] valid;

    ptr_t head;
    ptr_t head_p1;
    ptr_t head_p2;
    ptr_t tail;
    ptr_t tail_p1;
    ptr_t tail_p2;
    ptr_t slot0_ptr;

    logic       accept;
    logic       bj_a;
    logic       bj_b;
    logic       mm;
    logic       b_reads_rt;
    logic       raw_reg;
    logic       raw_hilo;
    logic [1:0] issue_en;

    issue_entry_t issued_a;
    issue_entry_t issued_b;

    assign head_p1 = head + ptr_t'(1);
    assign head_p2 = head + ptr_t'(2);
    assign tail_p1 = tail + ptr_t'(1);
    assign tail_p2 = tail + ptr_t'(2);

    // slot 0 follows slot 1 when both come in, else it takes the tail
    assign slot0_ptr = dec_valid[1] ? tail_p1 : tail;

    assign dec_ready = !(dec_valid[1] && valid[tail]) && !(dec_valid[0] && valid[slot0_ptr]);
    assign accept    = dec_ready && !flush;

    assign head_a       = entries[head];
    assign head_b       = entries[head_p1];
    assign head_a_valid = valid[head];
    assign head_b_valid = valid[head_p1];

    assign bj_a = head_a.ctl.branch || head_a.ctl.jump || head_a.ctl.jr;
    assign bj_b = head_b.ctl.branch || head_b.ctl.jump || head_b.ctl.jr;

    // slot b is the delay slot whenever the older one branches
    assign head_b_delay_slot = bj_a;

    assign mm = (head_a.ctl.memtoreg || head_a.ctl.memwrite)
             && (head_b.ctl.memtoreg || head_b.ctl.memwrite);

    // an immediate-form instr only reads rt when it is a store
    assign b_reads_rt = !head_b.ctl.alusrc || head_b.ctl.memwrite;

    assign raw_reg = head_a.ctl.regwrite && (head_a.destreg != '0)
                  && ((head_a.destreg == head_b.instr.r_type.rs)
                   || (b_reads_rt && head_a.destreg == head_b.instr.r_type.rt));

    assign raw_hilo = (head_a.ctl.hiwrite && head_b.ctl.hitoreg)
                   || (head_a.ctl.lowrite && head_b.ctl.lotoreg);

    // a branch waits for its delay slot, then both go together
    assign issue_en[1] = head_a_valid && !(bj_a && !head_b_valid);
    assign issue_en[0] = head_a_valid && head_b_valid
                      && (bj_a || !(bj_b || raw_reg || raw_hilo || mm));

    always_comb
    begin
        issued_a       = built_a;
        issued_a.valid = 1'b1;
        issued_b       = built_b;
        issued_b.valid = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            if (dec_valid[1])
                entries[tail] <= dec_in[1];
            if (dec_valid[0])
                entries[slot0_ptr] <= dec_in[0];
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            head      <= '0;
            tail      <= '0;
            valid     <= '0;
            issue_out <= '0;
        end
        else if (flush)
        begin
            head      <= '0;
            tail      <= '0;
            valid     <= '0;
            issue_out <= '0;
        end
        else
        begin
            if (!ex_stall)
            begin
                issue_out[1] <= issue_en[1] ? issued_a : '0;
                issue_out[0] <= issue_en[0] ? issued_b : '0;
                if (issue_en[1])
                    valid[head] <= 1'b0;
                if (issue_en[0])
                    valid[head_p1] <= 1'b0;
                case (issue_en)
                    2'b11:   head <= head_p2;
                    2'b10:   head <= head_p1;
                    default: head <= head;
                endcase
            end

            // freed and filled slots never coincide, see dec_ready
            if (accept)
            begin
                if (dec_valid[1])
                    valid[tail] <= 1'b1;
                if (dec_valid[0])
                    valid[slot0_ptr] <= 1'b1;
                case (dec_valid)
                    2'b11:   tail <= tail_p2;
                    2'b10:   tail <= tail_p1;
                    2'b01:   tail <= tail_p1;
                    default: tail <= tail;
                endcase
            end
        end
    end

endmodule

// ==== hdl/operand_fetch.sv ====
`timescale 1ns/1ps

module operand_fetch (
    input  issue_pkg::decode_entry_t entry,
    input  logic                     is_delay_slot,
    output issue_pkg::reg_addr_t     rs_addr,
    output issue_pkg::reg_addr_t     rt_addr,
    input  issue_pkg::word_t         rs_data,
    input  issue_pkg::word_t         rt_data,
    input  issue_pkg::word_t         hi,
    input  issue_pkg::word_t         lo,
    output issue_pkg::issue_entry_t  built
);

    import issue_pkg::*;

    logic [15:0] imm;
    word_t       imm_ext;

    // register fields through the r-type layout
    assign rs_addr = entry.instr.r_type.rs;
    assign rt_addr = entry.instr.r_type.rt;

    // immediate through the i-type layout
    assign imm = entry.instr.i_type.imm;

    assign imm_ext = entry.ctl.signext ? {{16{imm[15]}}, imm} : {16'h0000, imm};

    always_comb
    begin
        built            = '0;
        built.pc         = entry.pc;
        built.ctl        = entry.ctl;
        built.destreg    = entry.destreg;
        built.srca       = rs_data;
        built.srcb       = entry.ctl.alusrc ? imm_ext : rt_data;
        built.store_data = rt_data;
        built.hi         = hi;
        built.lo         = lo;
        built.delay_slot = is_delay_slot;

        // return address skips the delay slot
        if (entry.ctl.is_link)
            built.link_pc = entry.pc + 32'd8;
    end

endmodule

// ==== hdl/arch_regs.sv ====
`timescale 1ns/1ps

module arch_regs (
    input  logic                         clk,
    input  logic                         reset,
    input  issue_pkg::reg_addr_t [3:0]   raddr,
    output issue_pkg::word_t [3:0]       rdata,
    output issue_pkg::word_t             hi,
    output issue_pkg::word_t             lo,
    input  issue_pkg::writeback_t [1:0]  wb
);

    import issue_pkg::*;

    word_t      regs [32];
    word_t      hi_q;
    word_t      lo_q;
    logic [1:0] wr_en;

    // r0 is never written, so it stays at its reset value of zero
    assign wr_en[1] = wb[1].en && (wb[1].addr != '0);
    assign wr_en[0] = wb[0].en && (wb[0].addr != '0);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
            hi_q <= '0;
            lo_q <= '0;
        end
        else
        begin
            // port 0 comes last so it wins a shared address
            if (wr_en[1])
                regs[wb[1].addr] <= wb[1].data;
            if (wr_en[0])
                regs[wb[0].addr] <= wb[0].data;
            if (wb[1].hi_en)
                hi_q <= wb[1].hi;
            if (wb[0].hi_en)
                hi_q <= wb[0].hi;
            if (wb[1].lo_en)
                lo_q <= wb[1].lo;
            if (wb[0].lo_en)
                lo_q <= wb[0].lo;
        end
    end

    // write-first bypass, same priority as the write
    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            rdata[i] = regs[raddr[i]];
            if (wr_en[1] && wb[1].addr == raddr[i])
                rdata[i] = wb[1].data;
            if (wr_en[0] && wb[0].addr == raddr[i])
                rdata[i] = wb[0].data;
        end

        hi = hi_q;
        if (wb[1].hi_en)
            hi = wb[1].hi;
        if (wb[0].hi_en)
            hi = wb[0].hi;

        lo = lo_q;
        if (wb[1].lo_en)
            lo = wb[1].lo;
        if (wb[0].lo_en)
            lo = wb[0].lo;
    end

endmodule

// ==== hdl/issue_pkg.sv ====
package issue_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // primary opcode values
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct values under OP_SPECIAL
    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_JR      = 6'h08;
    localparam logic [5:0] FN_JALR    = 6'h09;
    localparam logic [5:0] FN_MFHI    = 6'h10;
    localparam logic [5:0] FN_MTHI    = 6'h11;
    localparam logic [5:0] FN_MFLO    = 6'h12;
    localparam logic [5:0] FN_MTLO    = 6'h13;
    localparam logic [5:0] FN_MULT    = 6'h18;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;

    // jal and jalr write here
    localparam reg_addr_t LINK_REG = 5'd31;

    typedef struct packed {
        logic [5:0] op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_type_t;

    typedef struct packed {
        logic [5:0]  op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_type_t;

    // one raw instruction word, two field layouts
    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
    } instr_word_u;

    typedef struct packed {
        logic regwrite;
        logic memtoreg;
        logic memwrite;
        logic alusrc;
        logic signext;
        logic branch;
        logic jump;
        logic jr;
        logic is_link;
        logic hiwrite;
        logic lowrite;
        logic hitoreg;
        logic lotoreg;
    } ctl_t;

    typedef struct packed {
        word_t       pc;
        instr_word_u instr;
        ctl_t        ctl;
        reg_addr_t   destreg;
    } decode_entry_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        ctl_t      ctl;
        reg_addr_t destreg;
        word_t     srca;
        word_t     srcb;
        word_t     store_data;
        word_t     hi;
        word_t     lo;
        logic      delay_slot;
        word_t     link_pc;
    } issue_entry_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
        logic      hi_en;
        logic      lo_en;
        word_t     hi;
        word_t     lo;
    } writeback_t;

endpackage
